// ==== list.f ====
+incdir+verilog
verilog/wb_pkg.sv
verilog/video_if.sv
verilog/frame_stats.sv
verilog/gain_calc.sv
verilog/pixel_correct.sv
verilog/wb_apb_regs.sv
verilog/white_balance_top.sv
tb/tb_clk_gen.sv
tb/tb_white_balance.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the white balance testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_white_balance \
    -f list.f \
    -o sim_wb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_wb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps

// 20 ns clock, reset low for the first 8 cycles
module tb_clk_gen (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk  = 1'b0;
        o_rstn = 1'b0;
        repeat (8) @(posedge o_clk);
        @(negedge o_clk);
        o_rstn = 1'b1;
    end

    always #10 o_clk = ~o_clk;

endmodule : tb_clk_gen

// ==== tb/tb_white_balance.sv ====
`timescale 1ns/10ps
`include "wb_settings.svh"

module tb_white_balance;

    typedef struct packed {
        logic               hsync;
        logic               vsync;
        logic               de;
        logic [7:0]         r;
        logic [7:0]         g;
        logic [7:0]         b;
        logic [`WB_X_W-1:0] x;
        logic [`WB_Y_W-1:0] y;
    } beat_t;

    logic               clk;
    logic               rstn;
    logic               i_hsync;
    logic               i_vsync;
    logic               i_de;
    logic [7:0]         i_r;
    logic [7:0]         i_g;
    logic [7:0]         i_b;
    logic [`WB_X_W-1:0] i_x;
    logic [`WB_Y_W-1:0] i_y;
    logic               i_psel;
    logic               i_penable;
    logic               i_pwrite;
    logic [7:0]         i_paddr;
    logic [31:0]        i_pwdata;
    logic               o_hsync;
    logic               o_vsync;
    logic               o_de;
    logic [7:0]         o_r;
    logic [7:0]         o_g;
    logic [7:0]         o_b;
    logic [`WB_X_W-1:0] o_x;
    logic [`WB_Y_W-1:0] o_y;
    logic [31:0]        o_prdata;
    logic               o_pready;
    logic               o_pslverr;

    int mismatches = 0;
    int timeouts   = 0;

    // Reference model state
    int m_sum [3];
    int fr_sum [3];
    int exp_gain [3];
    bit m_refresh;
    bit m_pend;
    bit m_en;

    beat_t beats [$];
    beat_t in_beat;
    beat_t chk;
    bit    chk_valid = 1'b0;

    tb_clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rstn(rstn)
    );

    white_balance_top i_white_balance_top (
        .clk      (clk),
        .rstn     (rstn),
        .i_hsync  (i_hsync),
        .i_vsync  (i_vsync),
        .i_de     (i_de),
        .i_r      (i_r),
        .i_g      (i_g),
        .i_b      (i_b),
        .i_x      (i_x),
        .i_y      (i_y),
        .i_psel   (i_psel),
        .i_penable(i_penable),
        .i_pwrite (i_pwrite),
        .i_paddr  (i_paddr),
        .i_pwdata (i_pwdata),
        .o_hsync  (o_hsync),
        .o_vsync  (o_vsync),
        .o_de     (o_de),
        .o_r      (o_r),
        .o_g      (o_g),
        .o_b      (o_b),
        .o_x      (o_x),
        .o_y      (o_y),
        .o_prdata (o_prdata),
        .o_pready (o_pready),
        .o_pslverr(o_pslverr)
    );

    task automatic report_mismatch(input string name, input longint got, input longint exp);
        $display("Mismatch at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic expect_val(input string name, input longint got, input longint exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    // Pixel times 8.8 gain saturated to 8 bits
    function automatic int scale_pixel(input int pix, input int gain);
        int v;
        v = (pix * gain) >> 8;
        return (v > 255) ? 255 : v;
    endfunction

    function automatic int gain_rule(input int avg, input int target);
        int q;
        if (avg == 0) begin
            return 256;
        end
        q = (target * 256) / avg;
        return (q > 65535) ? 65535 : q;
    endfunction

    // Expected output beats lined up 4 clocks after their input
    always @(posedge clk) begin
        in_beat.hsync = i_hsync;
        in_beat.vsync = i_vsync;
        in_beat.de    = i_de;
        in_beat.x     = i_x;
        in_beat.y     = i_y;
        in_beat.r     = m_en ? 8'(scale_pixel(i_r, exp_gain[0])) : i_r;
        in_beat.g     = m_en ? 8'(scale_pixel(i_g, exp_gain[1])) : i_g;
        in_beat.b     = m_en ? 8'(scale_pixel(i_b, exp_gain[2])) : i_b;
        beats.push_back(in_beat);
        if (beats.size() >= `WB_PIX_LATENCY) begin
            chk       <= beats.pop_front();
            chk_valid <= 1'b1;
        end
    end

    a_hsync: assert property (@(negedge clk) chk_valid |-> o_hsync == chk.hsync)
        else report_mismatch("o_hsync", o_hsync, chk.hsync);
    a_vsync: assert property (@(negedge clk) chk_valid |-> o_vsync == chk.vsync)
        else report_mismatch("o_vsync", o_vsync, chk.vsync);
    a_de: assert property (@(negedge clk) chk_valid |-> o_de == chk.de)
        else report_mismatch("o_de", o_de, chk.de);
    a_x: assert property (@(negedge clk) chk_valid && chk.de |-> o_x == chk.x)
        else report_mismatch("o_x", o_x, chk.x);
    a_y: assert property (@(negedge clk) chk_valid && chk.de |-> o_y == chk.y)
        else report_mismatch("o_y", o_y, chk.y);
    a_r: assert property (@(negedge clk) chk_valid && chk.de |-> o_r == chk.r)
        else report_mismatch("o_r", o_r, chk.r);
    a_g: assert property (@(negedge clk) chk_valid && chk.de |-> o_g == chk.g)
        else report_mismatch("o_g", o_g, chk.g);
    a_b: assert property (@(negedge clk) chk_valid && chk.de |-> o_b == chk.b)
        else report_mismatch("o_b", o_b, chk.b);
    a_pready: assert property (@(posedge clk) disable iff (!rstn) o_pready)
        else report_mismatch("o_pready", o_pready, 1);

    task automatic apb_xfer(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        n = 0;
        @(negedge clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge clk);
        i_penable = 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!o_pready && n < 16);
        if (!o_pready) begin
            $display("APB transfer to 0x%0h never saw pready", addr);
            timeouts++;
        end
        rdata     = o_prdata;
        err       = o_pslverr;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        expect_val("o_pslverr", err, 0);
        if (addr == `WB_ADDR_CTRL) begin
            m_en = data[0];
            if (data[1]) begin
                m_pend = 1'b1;
            end
        end
    endtask

    task automatic apb_read_check(input string name, input logic [7:0] addr, input int exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        expect_val(name, rd, exp);
        expect_val("o_pslverr", err, 0);
    endtask

    task automatic drive_idle(input int n, input bit vs);
        repeat (n) begin
            @(negedge clk);
            i_de    = 1'b0;
            i_hsync = 1'b0;
            i_vsync = vs;
            i_r     = 8'h00;
            i_g     = 8'h00;
            i_b     = 8'h00;
            i_x     = '0;
            i_y     = '0;
        end
    endtask

    // Refresh policy and gain rule applied at the vsync edges
    task automatic update_model();
        int avg [3];
        int target;
        if (m_refresh) begin
            for (int c = 0; c < 3; c++) begin
                m_sum[c] += fr_sum[c];
            end
        end
        m_refresh = m_pend || (m_sum[0] <= `WB_DARK_THRESH && m_sum[1] <= `WB_DARK_THRESH &&
                               m_sum[2] <= `WB_DARK_THRESH);
        if (m_refresh) begin
            for (int c = 0; c < 3; c++) begin
                avg[c] = m_sum[c] >> `WB_AREA_SHIFT;
            end
            target = (avg[0] + avg[1] + avg[2]) / 3;
            for (int c = 0; c < 3; c++) begin
                exp_gain[c] = gain_rule(avg[c], target);
                m_sum[c]    = 0;
            end
        end
        m_pend = 1'b0;
    endtask

    task automatic send_frame(input int r_lo, input int r_hi, input int g_lo, input int g_hi,
                              input int b_lo, input int b_hi);
        for (int c = 0; c < 3; c++) begin
            fr_sum[c] = 0;
        end
        for (int y = 0; y < `WB_V_ACT; y++) begin
            for (int x = 0; x < `WB_H_ACT; x++) begin
                @(negedge clk);
                i_de    = 1'b1;
                i_hsync = 1'b0;
                i_vsync = 1'b0;
                i_x     = x[`WB_X_W-1:0];
                i_y     = y[`WB_Y_W-1:0];
                i_r     = 8'(r_lo + $urandom % (r_hi - r_lo + 1));
                i_g     = 8'(g_lo + $urandom % (g_hi - g_lo + 1));
                i_b     = 8'(b_lo + $urandom % (b_hi - b_lo + 1));
                fr_sum[0] += i_r;
                fr_sum[1] += i_g;
                fr_sum[2] += i_b;
            end
            drive_idle(1, 1'b0);
            @(negedge clk);
            i_de    = 1'b0;
            i_hsync = 1'b1;
            @(negedge clk);
            drive_idle(1, 1'b0);
        end
        drive_idle(8, 1'b0);
        drive_idle(4, 1'b1);
        drive_idle(120, 1'b0);
        update_model();
    endtask

    // Poll STATUS until the divider is idle and then compare gains and refresh
    task automatic check_after_frame();
        logic [31:0] rd;
        logic        err;
        int          n;
        n = 0;
        do begin
            apb_xfer(1'b0, `WB_ADDR_STATUS, 32'h0, rd, err);
            n++;
        end while (rd[1] && n < 100);
        if (rd[1]) begin
            $display("Gain calculation stayed busy too long");
            timeouts++;
        end
        expect_val("status.refresh", rd[0], m_refresh);
        apb_read_check("gain_r", `WB_ADDR_GAIN_R, exp_gain[0]);
        apb_read_check("gain_g", `WB_ADDR_GAIN_G, exp_gain[1]);
        apb_read_check("gain_b", `WB_ADDR_GAIN_B, exp_gain[2]);
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        int          n;
        void'($urandom(8));
        i_hsync   = 1'b0;
        i_vsync   = 1'b0;
        i_de      = 1'b0;
        i_r       = 8'h00;
        i_g       = 8'h00;
        i_b       = 8'h00;
        i_x       = '0;
        i_y       = '0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = 8'h00;
        i_pwdata  = 32'h0;
        m_refresh = 1'b1;
        m_pend    = 1'b0;
        m_en      = 1'b0;
        for (int c = 0; c < 3; c++) begin
            m_sum[c]    = 0;
            exp_gain[c] = 256;
        end

        n = 0;
        while (!rstn && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!rstn) begin
            $display("Reset was never released");
            timeouts++;
        end

        // Register values after reset
        apb_read_check("ctrl", `WB_ADDR_CTRL, 0);
        apb_read_check("status", `WB_ADDR_STATUS, 1);
        check_after_frame();
        apb_xfer(1'b0, 8'h14, 32'h0, rd, err);
        expect_val("o_pslverr", err, 1);

        // Red cast in bypass with statistics taken on request
        apb_write(`WB_ADDR_CTRL, 32'h2);
        send_frame(150, 220, 90, 140, 40, 90);
        check_after_frame();

        // Blue cast corrected while the bright frame drops refresh
        apb_write(`WB_ADDR_CTRL, 32'h1);
        send_frame(40, 100, 80, 130, 160, 240);
        check_after_frame();

        // Frozen gains under a green cast
        send_frame(60, 110, 170, 230, 50, 100);
        check_after_frame();

        apb_write(`WB_ADDR_CTRL, 32'h3);
        send_frame(120, 200, 60, 120, 90, 150);
        check_after_frame();

        // Dark frame keeps refresh set
        send_frame(0, 3, 0, 3, 0, 3);
        check_after_frame();
        send_frame(100, 180, 110, 170, 30, 80);
        check_after_frame();

        apb_read_check("ctrl", `WB_ADDR_CTRL, 1);
        drive_idle(10, 1'b0);

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #2000000;
        $display("The run did not finish in time");
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_white_balance

// ==== verilog/frame_stats.sv ====
`timescale 1ns/10ps
`include "wb_settings.svh"

module frame_stats (
    input  logic clk,
    input  logic rstn,
    video_if.snk vid,
    input  logic i_update_req,
    stats_if.src st,
    output logic o_refresh
);

    logic                 vsync_d;
    logic                 vs_rise;
    logic                 vs_fall;
    logic                 upd_pend;
    logic                 frame_dark;
    logic [`WB_SUM_W-1:0] cur_r;
    logic [`WB_SUM_W-1:0] cur_g;
    logic [`WB_SUM_W-1:0] cur_b;

    assign vs_rise = vid.vsync & ~vsync_d;
    assign vs_fall = ~vid.vsync & vsync_d;

    assign frame_dark = (cur_r <= `WB_DARK_THRESH) &&
                        (cur_g <= `WB_DARK_THRESH) &&
                        (cur_b <= `WB_DARK_THRESH);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= vid.vsync;
        end
    end

    // Request held until the next frame starts
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            upd_pend <= 1'b0;
        end else if (i_update_req) begin
            upd_pend <= 1'b1;
        end else if (vs_fall) begin
            upd_pend <= 1'b0;
        end
    end

    // Decided once per frame at vsync rise
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_refresh <= 1'b1;
        end else if (vs_rise) begin
            o_refresh <= upd_pend | frame_dark;
        end
    end

    // Running sums, frozen while refresh is low
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_r <= '0;
            cur_g <= '0;
            cur_b <= '0;
        end else if (o_refresh) begin
            if (vs_fall) begin
                cur_r <= '0;
                cur_g <= '0;
                cur_b <= '0;
            end else if (vid.de) begin
                cur_r <= cur_r + {{(`WB_SUM_W-8){1'b0}}, vid.r};
                cur_g <= cur_g + {{(`WB_SUM_W-8){1'b0}}, vid.g};
                cur_b <= cur_b + {{(`WB_SUM_W-8){1'b0}}, vid.b};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_refresh && vs_fall) begin
            st.sum_r <= cur_r;
            st.sum_g <= cur_g;
            st.sum_b <= cur_b;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            st.sums_valid <= 1'b0;
        end else begin
            st.sums_valid <= o_refresh & vs_fall;
        end
    end

endmodule : frame_stats

// ==== verilog/gain_calc.sv ====
`timescale 1ns/10ps
`include "wb_settings.svh"

module gain_calc import wb_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    stats_if.snk  st,
    output gain_t o_gain_r,
    output gain_t o_gain_g,
    output gain_t o_gain_b,
    output logic  o_gain_busy
);

    div_state_e  state;
    logic [1:0]  ch;
    logic [3:0]  cnt;
    logic [7:0]  avg [3];
    logic [7:0]  target;
    logic [7:0]  divisor;
    logic [7:0]  rem;
    logic [15:0] quo;
    gain_t       shadow [2];

    logic [9:0]  avg_sum;
    logic [9:0]  target_w;
    logic [8:0]  rem_sh;
    logic [8:0]  diff;
    logic        fits;
    logic [15:0] quo_nxt;
    gain_t       gain_done;

    // Gray target straight from the incoming sums
    always_comb begin
        avg_sum  = {2'b00, st.sum_r[`WB_AREA_SHIFT +: 8]} +
                   {2'b00, st.sum_g[`WB_AREA_SHIFT +: 8]} +
                   {2'b00, st.sum_b[`WB_AREA_SHIFT +: 8]};
        target_w = avg_sum / 10'd3;
    end

    // One restoring step per clock
    always_comb begin
        rem_sh    = {rem, quo[15]};
        diff      = rem_sh - {1'b0, divisor};
        fits      = rem_sh >= {1'b0, divisor};
        quo_nxt   = {quo[14:0], fits};
        gain_done = (divisor == 8'd0) ? `WB_GAIN_ONE : quo_nxt;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= DIV_IDLE;
            ch          <= 2'd0;
            cnt         <= 4'd0;
            o_gain_busy <= 1'b0;
            o_gain_r    <= `WB_GAIN_ONE;
            o_gain_g    <= `WB_GAIN_ONE;
            o_gain_b    <= `WB_GAIN_ONE;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (st.sums_valid) begin
                        ch          <= 2'd0;
                        o_gain_busy <= 1'b1;
                        state       <= DIV_NEXT;
                    end
                end
                DIV_NEXT: begin
                    cnt   <= 4'd0;
                    state <= DIV_RUN;
                end
                DIV_RUN: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd15) begin
                        if (ch == 2'd2) begin
                            // All three land together
                            o_gain_r    <= shadow[0];
                            o_gain_g    <= shadow[1];
                            o_gain_b    <= gain_done;
                            o_gain_busy <= 1'b0;
                            state       <= DIV_IDLE;
                        end else begin
                            ch    <= ch + 2'd1;
                            state <= DIV_NEXT;
                        end
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && st.sums_valid) begin
            avg[0] <= st.sum_r[`WB_AREA_SHIFT +: 8];
            avg[1] <= st.sum_g[`WB_AREA_SHIFT +: 8];
            avg[2] <= st.sum_b[`WB_AREA_SHIFT +: 8];
            target <= target_w[7:0];
        end
        if (state == DIV_NEXT) begin
            divisor <= avg[ch];
            rem     <= 8'd0;
            quo     <= {target, 8'h00};
        end else if (state == DIV_RUN) begin
            rem <= fits ? diff[7:0] : rem_sh[7:0];
            quo <= quo_nxt;
            if (cnt == 4'd15 && ch != 2'd2) begin
                shadow[ch[0]] <= gain_done;
            end
        end
    end

endmodule : gain_calc

// ==== verilog/pixel_correct.sv ====
`timescale 1ns/10ps
`include "wb_settings.svh"

module pixel_correct import wb_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    video_if.snk  vid_in,
    input  gain_t i_gain_r,
    input  gain_t i_gain_g,
    input  gain_t i_gain_b,
    input  logic  i_en,
    video_if.src  vid_out
);

    localparam int DLY = `WB_PIX_LATENCY - 1;
    localparam int DW  = `WB_X_W + `WB_Y_W + 24;

    gain_t              gain [3];
    logic [7:0]         pix_s1 [3];
    logic [23:0]        prod_s2 [3];
    logic [7:0]         sat_s3 [3];
    logic [2:0]         ctl_d [DLY];
    logic [DW-1:0]      dat_d [DLY];
    logic [`WB_X_W-1:0] x_d;
    logic [`WB_Y_W-1:0] y_d;
    logic [7:0]         org_r;
    logic [7:0]         org_g;
    logic [7:0]         org_b;

    always_comb begin
        gain[0] = i_gain_r;
        gain[1] = i_gain_g;
        gain[2] = i_gain_b;
    end

    assign {x_d, y_d, org_r, org_g, org_b} = dat_d[DLY-1];

    // Stages 1 to 3, multiply then saturate
    always_ff @(posedge clk) begin
        pix_s1[0] <= vid_in.r;
        pix_s1[1] <= vid_in.g;
        pix_s1[2] <= vid_in.b;
        for (int i = 0; i < 3; i++) begin
            prod_s2[i] <= pix_s1[i] * gain[i];
            sat_s3[i]  <= (|prod_s2[i][23:16]) ? 8'hFF : prod_s2[i][15:8];
        end
    end

    // Side data aligned with sat_s3
    always_ff @(posedge clk) begin
        dat_d[0] <= {vid_in.x, vid_in.y, vid_in.r, vid_in.g, vid_in.b};
        for (int i = 1; i < DLY; i++) begin
            dat_d[i] <= dat_d[i-1];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DLY; i++) begin
                ctl_d[i] <= 3'b000;
            end
        end else begin
            ctl_d[0] <= {vid_in.hsync, vid_in.vsync, vid_in.de};
            for (int i = 1; i < DLY; i++) begin
                ctl_d[i] <= ctl_d[i-1];
            end
        end
    end

    // Stage 4, output select
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vid_out.hsync <= 1'b0;
            vid_out.vsync <= 1'b0;
            vid_out.de    <= 1'b0;
        end else begin
            {vid_out.hsync, vid_out.vsync, vid_out.de} <= ctl_d[DLY-1];
        end
    end

    always_ff @(posedge clk) begin
        vid_out.x <= x_d;
        vid_out.y <= y_d;
        vid_out.r <= i_en ? sat_s3[0] : org_r;
        vid_out.g <= i_en ? sat_s3[1] : org_g;
        vid_out.b <= i_en ? sat_s3[2] : org_b;
    end

endmodule : pixel_correct

// ==== verilog/video_if.sv ====
`timescale 1ns/10ps
`include "wb_settings.svh"

// One pixel beat per clock, valid while de is high
interface video_if;

    logic               hsync;
    logic               vsync;
    logic               de;
    logic [7:0]         r;
    logic [7:0]         g;
    logic [7:0]         b;
    logic [`WB_X_W-1:0] x;
    logic [`WB_Y_W-1:0] y;

    modport src (
        output hsync, vsync, de, r, g, b, x, y
    );

    modport snk (
        input  hsync, vsync, de, r, g, b, x, y
    );

endinterface : video_if

// Frame sums, held between valid pulses
interface stats_if;

    logic [`WB_SUM_W-1:0] sum_r;
    logic [`WB_SUM_W-1:0] sum_g;
    logic [`WB_SUM_W-1:0] sum_b;
    logic                 sums_valid;

    modport src (
        output sum_r, sum_g, sum_b, sums_valid
    );

    modport snk (
        input  sum_r, sum_g, sum_b, sums_valid
    );

endinterface : stats_if

// ==== verilog/wb_apb_regs.sv ====
`timescale 1ns/10ps

module wb_apb_regs import wb_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    input  logic        i_refresh,
    input  logic        i_gain_busy,
    input  gain_t       i_gain_r,
    input  gain_t       i_gain_g,
    input  gain_t       i_gain_b,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_en,
    output logic        o_update_req
);

    reg_addr_e addr;
    logic      access;
    logic      ctrl_wr;
    logic      mapped;

    assign addr     = reg_addr_e'(i_paddr);
    assign access   = i_psel & i_penable;
    assign ctrl_wr  = access & i_pwrite & (addr == REG_CTRL);

    // Zero wait states
    assign o_pready  = 1'b1;
    assign o_pslverr = access & ~mapped;

    always_comb begin
        mapped   = 1'b1;
        o_prdata = 32'h0;
        case (addr)
            REG_CTRL:   o_prdata = {31'h0, o_en};
            REG_STATUS: o_prdata = {30'h0, i_gain_busy, i_refresh};
            REG_GAIN_R: o_prdata = {16'h0, i_gain_r};
            REG_GAIN_G: o_prdata = {16'h0, i_gain_g};
            REG_GAIN_B: o_prdata = {16'h0, i_gain_b};
            default:    mapped   = 1'b0;
        endcase
    end

    // Update bit is self-clearing, reads back as 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_en         <= 1'b0;
            o_update_req <= 1'b0;
        end else begin
            o_update_req <= ctrl_wr & i_pwdata[1];
            if (ctrl_wr) begin
                o_en <= i_pwdata[0];
            end
        end
    end

endmodule : wb_apb_regs

// ==== verilog/wb_pkg.sv ====
`include "wb_settings.svh"

package wb_pkg;

    // Unsigned 8.8, 0x0100 is unity
    typedef logic [15:0] gain_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_NEXT
    } div_state_e;

    typedef enum logic [7:0] {
        REG_CTRL   = `WB_ADDR_CTRL,
        REG_STATUS = `WB_ADDR_STATUS,
        REG_GAIN_R = `WB_ADDR_GAIN_R,
        REG_GAIN_G = `WB_ADDR_GAIN_G,
        REG_GAIN_B = `WB_ADDR_GAIN_B
    } reg_addr_e;

endpackage : wb_pkg

// ==== verilog/wb_settings.svh ====
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Active frame, 16x8 by default
`define WB_H_ACT        16
`define WB_V_ACT        8

// Coordinate field widths
`define WB_X_W          8
`define WB_Y_W          4

// log2 of the active area, average is a plain shift
`define WB_AREA_SHIFT   7
`define WB_SUM_W        (8 + `WB_AREA_SHIFT + 1)

// Dark frame when every sum stays at or below 4 per pixel
`define WB_DARK_THRESH  (4 * `WB_H_ACT * `WB_V_ACT)

`define WB_PIX_LATENCY  4
`define WB_GAIN_ONE     16'h0100

// APB byte offsets
`define WB_ADDR_CTRL    8'h00
`define WB_ADDR_STATUS  8'h04
`define WB_ADDR_GAIN_R  8'h08
`define WB_ADDR_GAIN_G  8'h0C
`define WB_ADDR_GAIN_B  8'h10

`endif

// ==== verilog/white_balance_top.sv ====
`timescale 1ns/10ps
`include "wb_settings.svh"

module white_balance_top import wb_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_hsync,
    input  logic               i_vsync,
    input  logic               i_de,
    input  logic [7:0]         i_r,
    input  logic [7:0]         i_g,
    input  logic [7:0]         i_b,
    input  logic [`WB_X_W-1:0] i_x,
    input  logic [`WB_Y_W-1:0] i_y,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [7:0]         i_paddr,
    input  logic [31:0]        i_pwdata,
    output logic               o_hsync,
    output logic               o_vsync,
    output logic               o_de,
    output logic [7:0]         o_r,
    output logic [7:0]         o_g,
    output logic [7:0]         o_b,
    output logic [`WB_X_W-1:0] o_x,
    output logic [`WB_Y_W-1:0] o_y,
    output logic [31:0]        o_prdata,
    output logic               o_pready,
    output logic               o_pslverr
);

    gain_t gain_r;
    gain_t gain_g;
    gain_t gain_b;
    logic  gain_busy;
    logic  wb_en;
    logic  update_req;
    logic  refresh;

    video_if u_vid_in ();
    video_if u_vid_out ();
    stats_if u_stats ();

    // Stream ports into the input interface
    assign u_vid_in.hsync = i_hsync;
    assign u_vid_in.vsync = i_vsync;
    assign u_vid_in.de    = i_de;
    assign u_vid_in.r     = i_r;
    assign u_vid_in.g     = i_g;
    assign u_vid_in.b     = i_b;
    assign u_vid_in.x     = i_x;
    assign u_vid_in.y     = i_y;

    assign o_hsync = u_vid_out.hsync;
    assign o_vsync = u_vid_out.vsync;
    assign o_de    = u_vid_out.de;
    assign o_r     = u_vid_out.r;
    assign o_g     = u_vid_out.g;
    assign o_b     = u_vid_out.b;
    assign o_x     = u_vid_out.x;
    assign o_y     = u_vid_out.y;

    frame_stats u_frame_stats (
        .clk         (clk),
        .rstn        (rstn),
        .vid         (u_vid_in.snk),
        .i_update_req(update_req),
        .st          (u_stats.src),
        .o_refresh   (refresh)
    );

    gain_calc u_gain_calc (
        .clk        (clk),
        .rstn       (rstn),
        .st         (u_stats.snk),
        .o_gain_r   (gain_r),
        .o_gain_g   (gain_g),
        .o_gain_b   (gain_b),
        .o_gain_busy(gain_busy)
    );

    pixel_correct u_pixel_correct (
        .clk     (clk),
        .rstn    (rstn),
        .vid_in  (u_vid_in.snk),
        .i_gain_r(gain_r),
        .i_gain_g(gain_g),
        .i_gain_b(gain_b),
        .i_en    (wb_en),
        .vid_out (u_vid_out.src)
    );

    wb_apb_regs u_wb_apb_regs (
        .clk         (clk),
        .rstn        (rstn),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .i_refresh   (refresh),
        .i_gain_busy (gain_busy),
        .i_gain_r    (gain_r),
        .i_gain_g    (gain_g),
        .i_gain_b    (gain_b),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_en        (wb_en),
        .o_update_req(update_req)
    );

endmodule : white_balance_top
